/* wb_ram_top.f */
+incdir+include
hdl/wb_ram_pkg.sv
hdl/synth_ram.sv
hdl/wb_ram_ctrl.sv
hdl/ram_clear_gen.sv
hdl/ram_port_mux.sv
hdl/wb_ram_top.sv
verif/synth_ram_sva.sv
verif/wb_ram_tb.sv

/* Makefile */
# Verilator flow for the Wishbone RAM slave

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f wb_ram_top.f --top-module wb_ram_top
	verilator --lint-only --timing --assert -f wb_ram_top.f --top-module wb_ram_tb

sim:
	verilator --binary --timing --assert -f wb_ram_top.f --top-module wb_ram_tb \
	  -Mdir obj_dir -o wb_ram_sim
	./obj_dir/wb_ram_sim +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "^TESTBENCH PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

/* verif/wb_ram_tb.sv */
/* Testbench for the Wishbone RAM slave
   Classic-cycle driver, reference memory model and response checks */
`timescale 1ns/1ps
`default_nettype none

`include "wb_ram_config.svh"

module wb_ram_tb
  import wb_ram_pkg::*;
();

  localparam int IDX_W        = $clog2(`WB_RAM_WORDS);
  localparam int RESP_TIMEOUT = `WB_RAM_WORDS + 64;
  localparam int LAT          = 2;
  // Lane masks 1, 2, 4, 8, 3, c, 6 from the low nibble up
  localparam logic [27:0] LANE_MASKS = 28'h6c38421;

  logic                 clk;
  logic                 rst_n;
  logic                 cyc;
  logic                 stb;
  logic                 we;
  logic [`WB_ADR_W-1:0] adr;
  logic [3:0]           sel;
  logic [31:0]          dat_w;
  logic [31:0]          dat_r;
  logic                 ack;
  logic                 err;

  logic [31:0] ref_mem [0:`WB_RAM_WORDS-1];
  logic [31:0] exp_data_q [$];
  logic        exp_err_q [$];
  logic [31:0] rng_state;
  logic [31:0] cmp_word;
  logic        cmp_err;
  logic        hung;
  int          data_errors   = 0;
  int          resp_errors   = 0;
  int          proto_errors  = 0;
  int          assert_errors = 0;

  wb_ram_top i_wb_ram_top (
    .clk   (clk),
    .rst_n (rst_n),
    .cyc   (cyc),
    .stb   (stb),
    .we    (we),
    .adr   (adr),
    .sel   (sel),
    .dat_w (dat_w),
    .dat_r (dat_r),
    .ack   (ack),
    .err   (err)
  );

  bind synth_ram synth_ram_sva #(
    .WORDS (WORDS)
  ) i_synth_ram_sva (
    .clk        (clk),
    .ena        (ena),
    .wen        (wen),
    .addr       (addr),
    .wdata      (wdata),
    .rdata      (rdata),
    .rst_n      (wb_ram_tb.rst_n),
    .ack        (wb_ram_tb.ack),
    .err        (wb_ram_tb.err),
    .clear_done (wb_ram_tb.i_wb_ram_top.clear_done)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [`WB_ADR_W-1:0] word_adr(input logic [31:0] word,
                                                    input logic [1:0] off);
    return {word[`WB_RAM_AW-1:0], off};
  endfunction

  // Returns the old word and the response kind, then applies the masked write
  function automatic logic [31:0] model_access(input logic wr, input logic [`WB_ADR_W-1:0] a,
                                               input logic [3:0] mask, input logic [31:0] data,
                                               output logic is_err);
    logic [`WB_RAM_AW-1:0] word;
    logic [IDX_W-1:0]      idx;
    logic [31:0]           old;
    word   = a[`WB_ADR_W-1:2];
    idx    = word[IDX_W-1:0];
    old    = '0;
    is_err = (word >= `WB_RAM_AW'(`WB_RAM_WORDS));
    if (!is_err) begin
      old = ref_mem[idx];
      for (int b = 0; b < 4; b++) begin
        if (wr && mask[b]) begin
          ref_mem[idx][8*b +: 8] = data[8*b +: 8];
        end
      end
    end
    return old;
  endfunction

  task automatic check_data(input logic [31:0] exp, input logic [31:0] got);
    if (got !== exp) begin
      data_errors++;
      $display("error: dat_r got 0x%08h expected 0x%08h", got, exp);
    end
  endtask

  task automatic check_resp(input logic exp_err, input logic got_ack, input logic got_err);
    logic [1:0] exp;
    logic [1:0] got;
    exp = {!exp_err, exp_err};
    got = {got_ack, got_err};
    if (got !== exp) begin
      resp_errors++;
      $display("error: {ack,err} got 0x%h expected 0x%h", got, exp);
    end
  endtask

  task automatic bus_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      cyc <= 1'b0;
      stb <= 1'b0;
      we  <= 1'b0;
    end
  endtask

  // One classic cycle, held until ack or err, with latency bounds in cycles
  task automatic wb_access(input logic wr, input logic [`WB_ADR_W-1:0] a, input logic [3:0] m,
                           input logic [31:0] d, input int min_cyc, input int max_cyc);
    logic [31:0] exp_word;
    logic        exp_err;
    logic        seen;
    int          cycles;
    ram_state_e  st;
    if (hung) begin
      return;
    end
    exp_word = model_access(wr, a, m, d, exp_err);
    exp_data_q.push_back(exp_word);
    exp_err_q.push_back(exp_err);
    @(posedge clk);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= wr;
    adr   <= a;
    sel   <= m;
    dat_w <= d;
    seen   = 1'b0;
    cycles = 0;
    while (!seen && cycles < RESP_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      seen = (ack === 1'b1) || (err === 1'b1);
    end
    if (!seen) begin
      st   = i_wb_ram_top.i_wb_ram_ctrl.state;
      hung = 1'b1;
      proto_errors++;
      $display("no ack or err after %0d cycles, controller in %s", cycles, st.name());
    end else if (cycles < min_cyc || cycles > max_cyc) begin
      proto_errors++;
      $display("response took %0d cycles, expected %0d to %0d", cycles, min_cyc, max_cyc);
    end
  endtask

  // Each response is matched against the oldest outstanding request
  always @(negedge clk) begin
    if (ack === 1'b1 || err === 1'b1) begin
      if (exp_err_q.size() == 0) begin
        resp_errors++;
        $display("response seen with no request outstanding");
      end else begin
        cmp_word = exp_data_q.pop_front();
        cmp_err  = exp_err_q.pop_front();
        check_resp(cmp_err, ack, err);
        if (!cmp_err) begin
          check_data(cmp_word, dat_r);
        end
      end
    end
  end

  initial begin
    logic [31:0]          r;
    logic [31:0]          d;
    logic [`WB_ADR_W-1:0] a;
    clk       = 1'b0;
    rst_n    <= 1'b0;
    cyc      <= 1'b0;
    stb      <= 1'b0;
    we       <= 1'b0;
    adr      <= '0;
    sel      <= '0;
    dat_w    <= '0;
    hung      = 1'b0;
    rng_state = 32'd63988;
    for (int i = 0; i < `WB_RAM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    // Raised during the fill, answered only after it
    wb_access(1'b0, word_adr(32'd5, 2'd0), 4'hf, '0, `WB_RAM_WORDS + 1, RESP_TIMEOUT);
    for (int w = 0; w < `WB_RAM_WORDS; w++) begin
      wb_access(1'b0, word_adr(32'(w), 2'd0), 4'hf, '0, LAT, LAT);
    end

    // Second write returns the first write's word
    wb_access(1'b1, word_adr(32'd10, 2'd0), 4'hf, 32'h1234_5678, LAT, LAT);
    wb_access(1'b1, word_adr(32'd10, 2'd0), 4'hf, 32'hcafe_f00d, LAT, LAT);
    wb_access(1'b0, word_adr(32'd10, 2'd0), 4'h0, '0, LAT, LAT);

    wb_access(1'b1, word_adr(32'd20, 2'd0), 4'hf, 32'h1122_3344, LAT, LAT);
    for (int i = 0; i < 7; i++) begin
      d = next_rand();
      wb_access(1'b1, word_adr(32'd20, 2'(i)), LANE_MASKS[4*i +: 4], d, LAT, LAT);
      wb_access(1'b0, word_adr(32'd20, 2'd0), 4'h0, '0, LAT, LAT);
    end

    // Out of range, then the words a leak would alias
    wb_access(1'b1, word_adr(`WB_RAM_WORDS, 2'd0), 4'hf, 32'hdead_beef, LAT, LAT);
    wb_access(1'b1, word_adr(`WB_RAM_WORDS + 10, 2'd0), 4'hf, 32'h0bad_0bad, LAT, LAT);
    wb_access(1'b0, {`WB_ADR_W{1'b1}}, 4'hf, '0, LAT, LAT);
    wb_access(1'b0, word_adr(32'd0, 2'd0), 4'hf, '0, LAT, LAT);
    wb_access(1'b0, word_adr(32'd10, 2'd0), 4'hf, '0, LAT, LAT);

    for (int i = 0; i < 200; i++) begin
      r = next_rand();
      d = next_rand();
      if (r[7:4] == 4'h0) begin
        a = word_adr(32'(`WB_RAM_WORDS) + 32'(r[31:16]), r[13:12]);
      end else begin
        a = word_adr(32'(r[31:16]) % 32'(`WB_RAM_WORDS), r[13:12]);
      end
      wb_access(r[0], a, r[11:8], d, LAT, LAT);
      if (r[3:1] == 3'd0) begin
        bus_idle(1);
      end
    end
    bus_idle(2);

    $display("errors: data %0d, response %0d, protocol %0d, assertion %0d",
             data_errors, resp_errors, proto_errors, assert_errors);
    if (data_errors + resp_errors + proto_errors + assert_errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verif/synth_ram_sva.sv */
/* Bound checker for the single-port RAM
   Port sanity and quiet bus responses during the zero-fill */
`timescale 1ns/1ps
`default_nettype none

`include "wb_ram_config.svh"

module synth_ram_sva #(
  parameter int WORDS = 64
) (
  input logic                  clk,
  input logic                  ena,
  input logic [3:0]            wen,
  input logic [`WB_RAM_AW-1:0] addr,
  input logic [31:0]           wdata,
  input logic [31:0]           rdata,
  input logic                  rst_n,
  input logic                  ack,
  input logic                  err,
  input logic                  clear_done
);

  // Checks start once the port has left its power-up state
  logic [1:0] warm    = 2'b00;
  logic [1:0] rst_q   = 2'b00;
  logic       in_fill = 1'b1;

  always @(posedge clk) begin
    warm  <= {warm[0], 1'b1};
    rst_q <= {rst_q[0], rst_n};
    if (!rst_n) begin
      in_fill <= 1'b1;
    end else if (clear_done) begin
      in_fill <= 1'b0;
    end
  end

  a_rdata_hold: assert property (@(posedge clk) (warm[1] && !$past(ena)) |-> $stable(rdata))
    else begin
      $error("rdata changed while the port was disabled");
      wb_ram_tb.assert_errors = wb_ram_tb.assert_errors + 1;
    end

  a_addr_range: assert property (@(posedge clk)
    (warm[1] && ena) |-> (addr < `WB_RAM_AW'(WORDS)))
    else begin
      $error("enabled RAM access outside the memory");
      wb_ram_tb.assert_errors = wb_ram_tb.assert_errors + 1;
    end

  a_port_known: assert property (@(posedge clk)
    (warm[1] && ena) |-> !$isunknown({wen, addr, wdata}))
    else begin
      $error("unknown value on an enabled RAM port");
      wb_ram_tb.assert_errors = wb_ram_tb.assert_errors + 1;
    end

  // From two cycles after reset release until the fill ends
  a_fill_quiet: assert property (@(posedge clk) (rst_q[1] && in_fill) |-> (!ack && !err))
    else begin
      $error("bus response during the zero-fill");
      wb_ram_tb.assert_errors = wb_ram_tb.assert_errors + 1;
    end

endmodule

`default_nettype wire

/* hdl/wb_ram_top.sv */
/* Wishbone classic slave around a zero-filled single-port RAM
   Connects the controller, fill engine, port multiplexer and RAM */
`timescale 1ns/1ps
`default_nettype none

`include "wb_ram_config.svh"

module wb_ram_top import wb_ram_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 cyc,
  input  logic                 stb,
  input  logic                 we,
  input  logic [`WB_ADR_W-1:0] adr,
  input  logic [3:0]           sel,
  input  logic [31:0]          dat_w,
  output logic [31:0]          dat_r,
  output logic                 ack,
  output logic                 err
);

  port_src_e             src;
  logic                  port_en;
  logic                  clear_run;
  logic                  clear_done;
  logic [`WB_RAM_AW-1:0] clear_addr;
  logic                  addr_ok;
  logic                  ram_ena;
  logic [3:0]            ram_wen;
  logic [`WB_RAM_AW-1:0] ram_addr;
  logic [31:0]           ram_wdata;

  wb_ram_ctrl i_wb_ram_ctrl (
    .clk        (clk),
    .rst_n      (rst_n),
    .cyc        (cyc),
    .stb        (stb),
    .addr_ok    (addr_ok),
    .clear_done (clear_done),
    .src        (src),
    .port_en    (port_en),
    .clear_run  (clear_run),
    .ack        (ack),
    .err        (err)
  );

  ram_clear_gen i_ram_clear_gen (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_run  (clear_run),
    .clear_addr (clear_addr),
    .clear_done (clear_done)
  );

  ram_port_mux i_ram_port_mux (
    .src        (src),
    .port_en    (port_en),
    .we         (we),
    .adr        (adr),
    .sel        (sel),
    .dat_w      (dat_w),
    .clear_addr (clear_addr),
    .addr_ok    (addr_ok),
    .ena        (ram_ena),
    .wen        (ram_wen),
    .addr       (ram_addr),
    .wdata      (ram_wdata)
  );

  // Read data goes straight out, valid in the ack cycle
  synth_ram #(
    .WORDS (`WB_RAM_WORDS)
  ) i_synth_ram (
    .clk   (clk),
    .ena   (ram_ena),
    .wen   (ram_wen),
    .addr  (ram_addr),
    .wdata (ram_wdata),
    .rdata (dat_r)
  );

endmodule

`default_nettype wire

/* hdl/ram_port_mux.sv */
/* RAM port multiplexer
   Steers zero-fill or bus signals onto the RAM and range-checks bus addresses */
`timescale 1ns/1ps
`default_nettype none

`include "wb_ram_config.svh"

module ram_port_mux import wb_ram_pkg::*; (
  input  port_src_e             src,
  input  logic                  port_en,
  input  logic                  we,
  input  logic [`WB_ADR_W-1:0]  adr,
  input  logic [3:0]            sel,
  input  logic [31:0]           dat_w,
  input  logic [`WB_RAM_AW-1:0] clear_addr,
  output logic                  addr_ok,
  output logic                  ena,
  output logic [3:0]            wen,
  output logic [`WB_RAM_AW-1:0] addr,
  output logic [31:0]           wdata
);

  logic [`WB_RAM_AW-1:0] bus_addr;

  // Word address, byte offset dropped
  assign bus_addr = adr[`WB_ADR_W-1:2];

  // Only range test in the design
  assign addr_ok = (bus_addr < `WB_RAM_AW'(`WB_RAM_WORDS));

  always_comb begin
    ena   = 1'b0;
    wen   = 4'b0000;
    addr  = bus_addr;
    wdata = dat_w;
    case (src)
      SRC_CLEAR: begin
        // Full-word zero write at the fill address
        ena   = 1'b1;
        wen   = 4'b1111;
        addr  = clear_addr;
        wdata = '0;
      end
      SRC_BUS: begin
        ena   = port_en;
        // Reads enable the port with no lanes written
        wen   = we ? sel : 4'b0000;
        addr  = bus_addr;
        wdata = dat_w;
      end
      default: begin
        ena = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/ram_clear_gen.sv */
/* Zero-fill address generator
   Walks every RAM word once after reset */
`timescale 1ns/1ps
`default_nettype none

`include "wb_ram_config.svh"

module ram_clear_gen (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clear_run,
  output logic [`WB_RAM_AW-1:0] clear_addr,
  output logic                  clear_done
);

  // One word per cycle, stops on the last word
  // clear_done stays up until the next reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      clear_addr <= '0;
      clear_done <= 1'b0;
    end else if (clear_run && !clear_done) begin
      if (clear_addr == `WB_RAM_AW'(`WB_RAM_WORDS - 1)) begin
        clear_done <= 1'b1;
      end else begin
        clear_addr <= clear_addr + `WB_RAM_AW'(1);
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/wb_ram_ctrl.sv */
/* Wishbone RAM controller FSM
   Sequences the zero-fill, accepts bus requests and returns ack or err */
`timescale 1ns/1ps
`default_nettype none

module wb_ram_ctrl import wb_ram_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      cyc,
  input  logic      stb,
  input  logic      addr_ok,
  input  logic      clear_done,
  output port_src_e src,
  output logic      port_en,
  output logic      clear_run,
  output logic      ack,
  output logic      err
);

  ram_state_e state;
  ram_state_e state_nxt;
  logic       req;
  logic       accept;
  logic       resp_err;

  assign req = cyc && stb;

  // A request is only taken in ST_IDLE, one at a time
  assign accept = (state == ST_IDLE) && req;

  // In-range requests reach the RAM in the cycle they are seen
  assign port_en = accept && addr_ok;

  // The fill owns the port until the last word is written.
  // Once clear_done is up the port goes back to the bus side,
  // where port_en is still low
  assign src = ((state == ST_CLEAR) && !clear_done) ? SRC_CLEAR : SRC_BUS;

  assign clear_run = (state == ST_CLEAR);

  always_comb begin
    state_nxt = state;
    case (state)
      ST_CLEAR: begin
        if (clear_done) begin
          state_nxt = ST_IDLE;
        end
      end
      ST_IDLE: begin
        if (req) begin
          state_nxt = ST_RESP;
        end
      end
      ST_RESP: begin
        state_nxt = ST_IDLE;
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= ST_CLEAR;
    end else begin
      state <= state_nxt;
    end
  end

  // Response kind, decided from the range flag at acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      resp_err <= !addr_ok;
    end
  end

  // One-cycle response after acceptance
  // A master that has dropped cyc gets no response
  assign ack = (state == ST_RESP) && !resp_err && cyc;
  assign err = (state == ST_RESP) && resp_err && cyc;

endmodule

`default_nettype wire

/* hdl/synth_ram.sv */
/* Single-port RAM, 32-bit words, read-first
   Per-byte write mask and port enable */
`timescale 1ns/1ps
`default_nettype none

`include "wb_ram_config.svh"

module synth_ram #(
  parameter int WORDS = 64
) (
  input  logic                  clk,
  input  logic                  ena,
  input  logic [3:0]            wen,
  input  logic [`WB_RAM_AW-1:0] addr,
  input  logic [31:0]           wdata,
  output logic [31:0]           rdata
);

  // Index width for the storage array
  localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;

  logic [31:0]      mem [0:WORDS-1];
  logic [IDX_W-1:0] idx;

  // Upper address bits are kept in range by the port multiplexer
  assign idx = addr[IDX_W-1:0];

  // Read-first port
  // The old word is captured before any lane is updated,
  // so a write cycle returns the previous contents
  always_ff @(posedge clk) begin
    if (ena) begin
      rdata <= mem[idx];
    end
  end

  // Byte-lane writes, one enable bit per lane
  always_ff @(posedge clk) begin
    if (ena) begin
      for (int b = 0; b < 4; b++) begin
        if (wen[b]) begin
          mem[idx][8*b +: 8] <= wdata[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/wb_ram_pkg.sv */
/* Wishbone RAM shared types
   Controller states and RAM port source selection */
`default_nettype none

package wb_ram_pkg;

  // Controller states
  // ST_CLEAR runs the zero-fill after reset
  // ST_IDLE waits for a Wishbone request
  // ST_RESP drives the one-cycle ack or err
  typedef enum logic [1:0] {
    ST_CLEAR = 2'd0,
    ST_IDLE  = 2'd1,
    ST_RESP  = 2'd2
  } ram_state_e;

  // Owner of the RAM port
  // SRC_CLEAR is the zero-fill engine
  // SRC_BUS is the Wishbone slave side
  typedef enum logic {
    SRC_CLEAR = 1'b0,
    SRC_BUS   = 1'b1
  } port_src_e;

endpackage

`default_nettype wire

/* include/wb_ram_config.svh */
/* Wishbone RAM configuration
   Memory depth and address widths */
`ifndef WB_RAM_CONFIG_SVH
`define WB_RAM_CONFIG_SVH

// Number of 32-bit words in the RAM
`define WB_RAM_WORDS 64

// RAM word-address width
`define WB_RAM_AW 22

// Wishbone byte-address width
// Word address is the bus address without its two low bits
`define WB_ADR_W 24

`endif
